// ==== Makefile ====
TOP = tb_osc_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f build.f --top-module $(TOP)

sim:
	rm -f sim.log
	verilator --binary --timing --assert --timescale 1ns/100ps -f build.f --top-module $(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -qx "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #4 clk_o = ~clk_o;
        end
    end

    // reset is held low for 16 rising edges and released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== bench/tb_osc_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_osc_core;

    import osc_pkg::*;

    localparam int OSC_COUNT  = 8;
    localparam int WAIT_LIMIT = 40;

    logic      clk;
    logic      rst_n;
    logic      host_wr;
    logic      host_rd;
    reg_addr_t host_addr;
    reg_data_t host_wdata;
    reg_data_t host_rdata;
    logic      run;
    logic      update;
    osc_idx_t  update_osc;
    reg_data_t update_phase;

    // reference image of the registers and the accumulators
    reg_data_t   reg_img [0:127];
    phase_t      acc_model [0:OSC_COUNT-1];
    reg_data_t   last_phase [0:OSC_COUNT-1];
    logic        seen [0:OSC_COUNT-1];
    int          next_osc;
    logic        phase_known;
    logic [31:0] lfsr_q;
    string       test_name;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    osc_core #(
        .OSC_COUNT (OSC_COUNT)
    ) DUT (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .host_wr_i      (host_wr),
        .host_rd_i      (host_rd),
        .host_addr_i    (host_addr),
        .host_wdata_i   (host_wdata),
        .host_rdata_o   (host_rdata),
        .run_i          (run),
        .update_o       (update),
        .update_osc_o   (update_osc),
        .update_phase_o (update_phase)
    );

    bind osc_register_ram tb_osc_core_assert u_ram_assert (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .update_i   (1'b0),
        .idle_i     (1'b1),
        .run_i      (1'b1),
        .wr_grant_i (wr_grant),
        .rd_grant_i (rd_grant)
    );

    bind osc_scanner tb_osc_core_assert u_scan_assert (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .update_i   (update_o),
        .idle_i     (state_q == osc_pkg::SCAN_IDLE),
        .run_i      (run_i),
        .wr_grant_i (1'b0),
        .rd_grant_i (1'b0)
    );

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value[i] = lfsr_q[0];
            lfsr_q   = lfsr_step(lfsr_q);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERR %s: expected %0h, actual %0h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s during %s", what, test_name);
        $display("TB FAILED");
        $fatal(1, "%s", what);
    endtask

    // one strobe, then enough idle cycles that the next access is 3 cycles later
    task automatic host_write(input reg_addr_t addr, input reg_data_t data);
        host_addr  = addr;
        host_wdata = data;
        host_wr    = 1'b1;
        @(negedge clk);
        host_wr = 1'b0;
        repeat (2) @(negedge clk);
        if (addr[6:5] != GROUP_ACC) begin
            reg_img[addr] = data;
        end
    endtask

    // read data is valid after the second edge following the strobe
    task automatic host_read(input reg_addr_t addr, output reg_data_t data);
        host_addr = addr;
        host_rd   = 1'b1;
        @(negedge clk);
        host_rd = 1'b0;
        repeat (2) @(negedge clk);
        data = host_rdata;
    endtask

    task automatic check_update();
        int        o;
        reg_data_t lo;
        reg_data_t hi;
        logic      enable;
        o      = next_osc;
        lo     = reg_img[{GROUP_FREQ_LO, osc_idx_t'(o)}];
        hi     = reg_img[{GROUP_FREQ_HI, osc_idx_t'(o)}];
        enable = reg_img[{GROUP_CONTROL, osc_idx_t'(o)}][CTRL_ENABLE_BIT];
        check_value({test_name, " osc"}, 32'(o), 32'(update_osc));
        if (phase_known) begin
            if (enable) begin
                acc_model[o] = acc_model[o] + {8'h00, hi, lo};
            end else if (seen[o]) begin
                // a disabled oscillator repeats the phase of its last visit
                check_value({test_name, " hold"}, 32'(last_phase[o]), 32'(update_phase));
            end
            check_value({test_name, " phase"}, 32'(acc_model[o][23:16]), 32'(update_phase));
            last_phase[o] = acc_model[o][23:16];
            seen[o]       = 1'b1;
        end
        next_osc = (o + 1) % OSC_COUNT;
    endtask

    task automatic wait_update();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!update) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_failure("timeout waiting for update_o");
            end
            @(negedge clk);
        end
        check_update();
    endtask

    task automatic tick_watch();
        @(negedge clk);
        if (update) begin
            check_update();
        end
    endtask

    task automatic program_oscillators(input logic zero);
        logic [31:0] r;
        for (int o = 0; o < OSC_COUNT; o++) begin
            take_bits(24, r);
            if (zero) begin
                r = '0;
            end
            // oscillator 1 always stays still and oscillator 2 always runs
            if (o == 1) begin
                r[16 + CTRL_ENABLE_BIT] = 1'b0;
            end
            if (o == 2 && !zero) begin
                r[16 + CTRL_ENABLE_BIT] = 1'b1;
            end
            host_write({GROUP_FREQ_LO, osc_idx_t'(o)}, r[7:0]);
            host_write({GROUP_FREQ_HI, osc_idx_t'(o)}, r[15:8]);
            host_write({GROUP_CONTROL, osc_idx_t'(o)}, r[23:16]);
        end
    endtask

    task automatic check_accumulators();
        reg_data_t rdata;
        for (int o = 0; o < OSC_COUNT; o++) begin
            host_read({GROUP_ACC, osc_idx_t'(o)}, rdata);
            check_value({test_name, " readback"}, 32'(acc_model[o][23:16]), 32'(rdata));
        end
    endtask

    initial begin
        reg_data_t   rdata;
        reg_addr_t   addr;
        logic [31:0] r;
        int          cycles;
        host_wr     = 1'b0;
        host_rd     = 1'b0;
        host_addr   = '0;
        host_wdata  = '0;
        run         = 1'b0;
        lfsr_q      = 32'h6f8e;
        next_osc    = 0;
        phase_known = 1'b0;
        test_name   = "reset";
        for (int o = 0; o < OSC_COUNT; o++) begin
            seen[o] = 1'b0;
        end
        cycles = 0;
        @(posedge clk);
        while (!rst_n) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_failure("timeout waiting for reset release");
            end
            @(posedge clk);
        end
        @(negedge clk);

        // one full scan with everything disabled and zero frequency
        test_name = "warmup";
        program_oscillators(1'b1);
        run = 1'b1;
        for (int i = 0; i < OSC_COUNT; i++) begin
            wait_update();
        end
        run = 1'b0;
        repeat (3) tick_watch();
        // only the top byte is visible, the low bits come up as zero in simulation
        for (int o = 0; o < OSC_COUNT; o++) begin
            host_read({GROUP_ACC, osc_idx_t'(o)}, rdata);
            acc_model[o] = {rdata, 16'h0000};
        end
        phase_known = 1'b1;

        test_name = "reg_readback";
        for (int i = 0; i < 24; i++) begin
            take_bits(7, r);
            addr = r[6:0];
            if (addr[6:5] == GROUP_ACC) begin
                addr[6:5] = GROUP_CONTROL;
            end
            take_bits(8, r);
            host_write(addr, r[7:0]);
            host_read(addr, rdata);
            check_value(test_name, 32'(reg_img[addr]), 32'(rdata));
        end

        test_name = "acc_write_ignored";
        for (int o = 0; o < OSC_COUNT; o++) begin
            host_write({GROUP_ACC, osc_idx_t'(o)}, ~acc_model[o][23:16]);
        end
        check_accumulators();

        test_name = "phase_accumulate";
        program_oscillators(1'b0);
        run = 1'b1;
        for (int i = 0; i < 3 * OSC_COUNT; i++) begin
            wait_update();
        end

        // stop at a random point inside a slot
        test_name = "run_stop";
        take_bits(3, r);
        repeat (r[2:0]) tick_watch();
        run = 1'b0;
        repeat (6) tick_watch();
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            assert (!update) else begin
                report_failure("update_o appeared after the scanner should have stopped");
            end
        end
        check_accumulators();

        test_name = "run_resume";
        run = 1'b1;
        for (int i = 0; i < 2 * OSC_COUNT; i++) begin
            wait_update();
        end
        run = 1'b0;
        repeat (3) tick_watch();
        check_accumulators();

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/tb_osc_core_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_osc_core_assert (
    input wire clk_i,
    input wire rst_n_i,
    input wire update_i,
    input wire idle_i,
    input wire run_i,
    input wire wr_grant_i,
    input wire rd_grant_i
);

    // one update per slot, so never two in a row
    update_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        update_i |=> !update_i)
        else $error("update_o was high on two consecutive cycles");

    // the RAM serves a write or a read in a cycle, never both
    grant_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(wr_grant_i && rd_grant_i))
        else $error("write grant and read grant in the same cycle");

    // the scanner may only start a slot while run_i is high
    idle_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (idle_i && !run_i) |=> idle_i)
        else $error("scanner left SCAN_IDLE with run_i low");

endmodule

`default_nettype wire

// ==== build.f ====
hw/osc_pkg.sv
hw/osc_register_ram.sv
hw/osc_host_port.sv
hw/osc_scanner.sv
hw/osc_core.sv
bench/tb_clock_gen.sv
bench/tb_osc_core_assert.sv
bench/tb_osc_core.sv

// ==== hw/osc_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module osc_core #(
    parameter int OSC_COUNT = 32
) (
    input  wire                clk_i,
    input  wire                rst_n_i,

    input  wire                host_wr_i,
    input  wire                host_rd_i,
    input  wire osc_pkg::reg_addr_t host_addr_i,
    input  wire osc_pkg::reg_data_t host_wdata_i,
    output osc_pkg::reg_data_t host_rdata_o,
    input  wire                run_i,

    output logic               update_o,
    output osc_pkg::osc_idx_t  update_osc_o,
    output osc_pkg::reg_data_t update_phase_o
);

    import osc_pkg::*;

    localparam int REG_ADDR_W = $bits(reg_addr_t);
    localparam int REG_DATA_W = $bits(reg_data_t);
    localparam int ACC_ADDR_W = $bits(osc_idx_t);
    localparam int ACC_DATA_W = $bits(phase_t);

    // host side of both RAMs
    logic      reg_wr_req;
    logic      reg_rd_req;
    reg_addr_t reg_addr;
    reg_data_t reg_wdata;
    reg_data_t reg_rdata;
    logic      acc_rd_req;
    osc_idx_t  acc_rd_osc;
    phase_t    acc_rdata;

    // scanner side of both RAMs
    reg_addr_t scan_reg_addr;
    reg_data_t scan_reg_data;
    osc_idx_t  scan_acc_addr;
    phase_t    scan_acc_data;
    logic      acc_wr_req;
    osc_idx_t  acc_wr_addr;
    phase_t    acc_wr_data;

    osc_host_port u_host_port (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .host_wr_i    (host_wr_i),
        .host_rd_i    (host_rd_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_rdata_o (host_rdata_o),
        .reg_wr_req_o (reg_wr_req),
        .reg_rd_req_o (reg_rd_req),
        .reg_addr_o   (reg_addr),
        .reg_wdata_o  (reg_wdata),
        .reg_rdata_i  (reg_rdata),
        .acc_rd_req_o (acc_rd_req),
        .acc_rd_osc_o (acc_rd_osc),
        .acc_rdata_i  (acc_rdata)
    );

    // frequency and control registers, the scanner reads them on port B
    osc_register_ram #(
        .PRIORITY_WRITE_PORTS (1),
        .PRIORITY_READ_PORTS  (1),
        .ADDR_WIDTH           (REG_ADDR_W),
        .DATA_WIDTH           (REG_DATA_W)
    ) reg_ram (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .pwr_req_i  (reg_wr_req),
        .pwr_addr_i (reg_addr),
        .pwr_data_i (reg_wdata),
        .prd_req_i  (reg_rd_req),
        .prd_addr_i (reg_addr),
        .prd_data_o (reg_rdata),
        .addr_a_i   ('0),
        .data_a_o   (),
        .addr_b_i   (scan_reg_addr),
        .data_b_o   (scan_reg_data)
    );

    // phase accumulators, one word per oscillator
    osc_register_ram #(
        .PRIORITY_WRITE_PORTS (1),
        .PRIORITY_READ_PORTS  (1),
        .ADDR_WIDTH           (ACC_ADDR_W),
        .DATA_WIDTH           (ACC_DATA_W)
    ) acc_ram (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .pwr_req_i  (acc_wr_req),
        .pwr_addr_i (acc_wr_addr),
        .pwr_data_i (acc_wr_data),
        .prd_req_i  (acc_rd_req),
        .prd_addr_i (acc_rd_osc),
        .prd_data_o (acc_rdata),
        .addr_a_i   (scan_acc_addr),
        .data_a_o   (scan_acc_data),
        .addr_b_i   ('0),
        .data_b_o   ()
    );

    osc_scanner #(
        .OSC_COUNT (OSC_COUNT)
    ) u_scanner (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .run_i          (run_i),
        .reg_addr_o     (scan_reg_addr),
        .reg_data_i     (scan_reg_data),
        .acc_addr_o     (scan_acc_addr),
        .acc_data_i     (scan_acc_data),
        .acc_wr_req_o   (acc_wr_req),
        .acc_wr_addr_o  (acc_wr_addr),
        .acc_wr_data_o  (acc_wr_data),
        .update_o       (update_o),
        .update_osc_o   (update_osc_o),
        .update_phase_o (update_phase_o)
    );

endmodule

`default_nettype wire

// ==== hw/osc_host_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module osc_host_port (
    input  wire                clk_i,
    input  wire                rst_n_i,

    input  wire                host_wr_i,
    input  wire                host_rd_i,
    input  wire osc_pkg::reg_addr_t host_addr_i,
    input  wire osc_pkg::reg_data_t host_wdata_i,
    output osc_pkg::reg_data_t host_rdata_o,

    output logic               reg_wr_req_o,
    output logic               reg_rd_req_o,
    output osc_pkg::reg_addr_t reg_addr_o,
    output osc_pkg::reg_data_t reg_wdata_o,
    input  wire osc_pkg::reg_data_t reg_rdata_i,

    output logic               acc_rd_req_o,
    output osc_pkg::osc_idx_t  acc_rd_osc_o,
    input  wire osc_pkg::phase_t acc_rdata_i
);

    import osc_pkg::*;

    logic [1:0] group;
    logic       is_acc;

    // address and data are held here until the RAM serves the request
    reg_addr_t addr_q;
    reg_data_t wdata_q;

    // remembers whether the last read went to the accumulator RAM
    logic sel_acc_q;

    // group field sits above the oscillator number
    assign group  = host_addr_i[$bits(reg_addr_t)-1 -: 2];
    assign is_acc = (group == GROUP_ACC);

    // writes to the accumulator group are read-only and get dropped here
    assign reg_wr_req_o = host_wr_i && !is_acc;
    assign reg_rd_req_o = host_rd_i && !is_acc;
    assign acc_rd_req_o = host_rd_i && is_acc;

    always_ff @(posedge clk_i) begin
        if (host_wr_i || host_rd_i) begin
            addr_q <= host_addr_i;
        end
        if (host_wr_i) begin
            wdata_q <= host_wdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sel_acc_q <= 1'b0;
        end else if (host_rd_i) begin
            sel_acc_q <= is_acc;
        end
    end

    assign reg_addr_o   = addr_q;
    assign reg_wdata_o  = wdata_q;
    assign acc_rd_osc_o = addr_q[$bits(osc_idx_t)-1:0];

    // only the top byte of the accumulator is visible to the host
    assign host_rdata_o = sel_acc_q ? acc_rdata_i[$bits(phase_t)-1 -: $bits(reg_data_t)]
                                    : reg_rdata_i;

endmodule

`default_nettype wire

// ==== hw/osc_pkg.sv ====
`default_nettype none

package osc_pkg;

    // register address is {group, oscillator}
    typedef logic [6:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;
    typedef logic [4:0] osc_idx_t;

    // 24-bit phase accumulator and 16-bit frequency word per oscillator
    typedef logic [23:0] phase_t;
    typedef logic [15:0] freq_t;

    // register groups selected by the upper two address bits
    localparam logic [1:0] GROUP_FREQ_LO = 2'd0;
    localparam logic [1:0] GROUP_FREQ_HI = 2'd1;
    localparam logic [1:0] GROUP_CONTROL = 2'd2;
    // read-only, returns the top byte of the accumulator
    localparam logic [1:0] GROUP_ACC     = 2'd3;

    // oscillator runs when this control bit is set
    localparam int CTRL_ENABLE_BIT = 0;

    // one oscillator slot walks through these states in order
    typedef enum logic [2:0] {
        SCAN_IDLE,
        SCAN_READ_LO,
        SCAN_READ_HI,
        SCAN_READ_CTL,
        SCAN_WRITE_ACC
    } scan_state_t;

endpackage

`default_nettype wire

// ==== hw/osc_register_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module osc_register_ram #(
    parameter int PRIORITY_WRITE_PORTS = 1,
    parameter int PRIORITY_READ_PORTS  = 1,
    parameter int ADDR_WIDTH           = 5,
    parameter int DATA_WIDTH           = 8
) (
    input  wire                                        clk_i,
    input  wire                                        rst_n_i,

    input  wire  [PRIORITY_WRITE_PORTS-1:0]            pwr_req_i,
    input  wire  [PRIORITY_WRITE_PORTS*ADDR_WIDTH-1:0] pwr_addr_i,
    input  wire  [PRIORITY_WRITE_PORTS*DATA_WIDTH-1:0] pwr_data_i,

    input  wire  [PRIORITY_READ_PORTS-1:0]             prd_req_i,
    input  wire  [PRIORITY_READ_PORTS*ADDR_WIDTH-1:0]  prd_addr_i,
    output logic [PRIORITY_READ_PORTS*DATA_WIDTH-1:0]  prd_data_o,

    input  wire  [ADDR_WIDTH-1:0]                      addr_a_i,
    output logic [DATA_WIDTH-1:0]                      data_a_o,

    input  wire  [ADDR_WIDTH-1:0]                      addr_b_i,
    output logic [DATA_WIDTH-1:0]                      data_b_o
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    // the storage itself, one word per address
    logic [DATA_WIDTH-1:0] mem_q [0:DEPTH-1];

    // pending flags, set by a request pulse and cleared when the port is served
    logic [PRIORITY_WRITE_PORTS-1:0] wr_pend_q;
    logic [PRIORITY_READ_PORTS-1:0]  rd_pend_q;

    // one-hot grant of the port served at the coming edge
    logic [PRIORITY_WRITE_PORTS-1:0] wr_ack;
    logic [PRIORITY_READ_PORTS-1:0]  rd_ack;
    logic                            wr_grant;
    logic                            rd_grant;

    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [DATA_WIDTH-1:0] wr_data;
    // the single-port read address, shared by the read ports and port A
    logic [ADDR_WIDTH-1:0] sp_addr;

    // walk from the highest port down so the lowest pending one wins
    always_comb begin
        wr_ack  = '0;
        wr_addr = '0;
        wr_data = '0;
        for (int i = PRIORITY_WRITE_PORTS - 1; i >= 0; i--) begin
            if (wr_pend_q[i]) begin
                wr_ack    = '0;
                wr_ack[i] = 1'b1;
                wr_addr   = pwr_addr_i[i*ADDR_WIDTH +: ADDR_WIDTH];
                wr_data   = pwr_data_i[i*DATA_WIDTH +: DATA_WIDTH];
            end
        end
    end

    assign wr_grant = |wr_ack;

    // a read port is only served in a cycle without a write
    always_comb begin
        rd_ack  = '0;
        sp_addr = addr_a_i;
        if (!wr_grant) begin
            for (int i = PRIORITY_READ_PORTS - 1; i >= 0; i--) begin
                if (rd_pend_q[i]) begin
                    rd_ack    = '0;
                    rd_ack[i] = 1'b1;
                    sp_addr   = prd_addr_i[i*ADDR_WIDTH +: ADDR_WIDTH];
                end
            end
        end
    end

    assign rd_grant = |rd_ack;

    // a request arriving on the same edge as the grant keeps the flag set
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_pend_q <= '0;
            rd_pend_q <= '0;
        end else begin
            wr_pend_q <= (wr_pend_q & ~wr_ack) | pwr_req_i;
            rd_pend_q <= (rd_pend_q & ~rd_ack) | prd_req_i;
        end
    end

    // write, or else one single-port read into a read register or port A
    always_ff @(posedge clk_i) begin
        if (wr_grant) begin
            mem_q[wr_addr] <= wr_data;
        end else begin
            for (int i = 0; i < PRIORITY_READ_PORTS; i++) begin
                if (rd_ack[i]) begin
                    prd_data_o[i*DATA_WIDTH +: DATA_WIDTH] <= mem_q[sp_addr];
                end
            end
            if (!rd_grant) begin
                data_a_o <= mem_q[sp_addr];
            end
        end
    end

    // port B reads every cycle without arbitration
    always_ff @(posedge clk_i) begin
        data_b_o <= mem_q[addr_b_i];
    end

endmodule

`default_nettype wire

// ==== hw/osc_scanner.sv ====
`timescale 1ns/100ps
`default_nettype none

module osc_scanner #(
    parameter int OSC_COUNT = 32
) (
    input  wire                clk_i,
    input  wire                rst_n_i,
    input  wire                run_i,

    output osc_pkg::reg_addr_t reg_addr_o,
    input  wire osc_pkg::reg_data_t reg_data_i,

    output osc_pkg::osc_idx_t  acc_addr_o,
    input  wire osc_pkg::phase_t acc_data_i,

    output logic               acc_wr_req_o,
    output osc_pkg::osc_idx_t  acc_wr_addr_o,
    output osc_pkg::phase_t    acc_wr_data_o,

    output logic               update_o,
    output osc_pkg::osc_idx_t  update_osc_o,
    output osc_pkg::reg_data_t update_phase_o
);

    import osc_pkg::*;

    scan_state_t state_q;
    osc_idx_t    osc_q;
    freq_t       freq_q;

    logic   last_osc;
    logic   enable;
    phase_t phase_next;

    assign last_osc = (osc_q == osc_idx_t'(OSC_COUNT - 1));

    // port B data lags its address by one cycle, so each byte is picked
    // up in the state after the one that addressed it
    always_comb begin
        case (state_q)
            SCAN_READ_HI:  reg_addr_o = {GROUP_FREQ_HI, osc_q};
            SCAN_READ_CTL: reg_addr_o = {GROUP_CONTROL, osc_q};
            default:       reg_addr_o = {GROUP_FREQ_LO, osc_q};
        endcase
    end

    // the accumulator address stays on the current oscillator for the whole slot
    assign acc_addr_o = osc_q;

    // control byte is on reg_data_i during SCAN_WRITE_ACC
    assign enable = reg_data_i[CTRL_ENABLE_BIT];

    // the sum wraps modulo 2^24 by width
    assign phase_next = enable ? acc_data_i + phase_t'(freq_q) : acc_data_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q      <= SCAN_IDLE;
            osc_q        <= '0;
            acc_wr_req_o <= 1'b0;
            update_o     <= 1'b0;
        end else begin
            acc_wr_req_o <= 1'b0;
            update_o     <= 1'b0;
            case (state_q)
                // slot boundary, the only place where run_i is looked at
                SCAN_IDLE: begin
                    if (run_i) begin
                        state_q <= SCAN_READ_LO;
                    end
                end
                SCAN_READ_LO: begin
                    state_q <= SCAN_READ_HI;
                end
                SCAN_READ_HI: begin
                    state_q <= SCAN_READ_CTL;
                end
                SCAN_READ_CTL: begin
                    state_q <= SCAN_WRITE_ACC;
                end
                SCAN_WRITE_ACC: begin
                    state_q      <= SCAN_IDLE;
                    acc_wr_req_o <= 1'b1;
                    update_o     <= 1'b1;
                    osc_q        <= last_osc ? '0 : osc_q + osc_idx_t'(1);
                end
                default: begin
                    state_q <= SCAN_IDLE;
                end
            endcase
        end
    end

    // frequency bytes and the write-back payload
    always_ff @(posedge clk_i) begin
        if (state_q == SCAN_READ_HI) begin
            freq_q[7:0] <= reg_data_i;
        end
        if (state_q == SCAN_READ_CTL) begin
            freq_q[15:8] <= reg_data_i;
        end
        if (state_q == SCAN_WRITE_ACC) begin
            acc_wr_addr_o <= osc_q;
            acc_wr_data_o <= phase_next;
        end
    end

    // the report mirrors the write that is being requested
    assign update_osc_o   = acc_wr_addr_o;
    assign update_phase_o = acc_wr_data_o[$bits(phase_t)-1 -: $bits(reg_data_t)];

endmodule

`default_nettype wire
